// File: Bender.yml
package:
  name: uart_boot_io

export_include_dirs:
  - include

sources:
  - files:
      - hdl/io_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - hdl/boot_loader.sv
      - hdl/dec_digits.sv
      - hdl/image_dumper.sv
      - hdl/io_top.sv
  - target: simulation
    files:
      - dv/uart_host.sv
      - dv/io_tb.sv

// File: dv/io_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_defines.svh"

module io_tb;

  localparam int half_bit    = 4;
  localparam int bit_cycles  = 2 * half_bit;
  localparam int img_side    = 4;
  localparam int n_words     = 3 * img_side * img_side;
  localparam int prog_words  = 10;
  localparam int n_tx_bytes  = 1 + 11 + 4 * n_words; // boot byte plus header plus four per word
  localparam int n_rx_bytes  = 4 + 4 * prog_words + 1;
  localparam int watchdog_ns = 2 * (n_tx_bytes + n_rx_bytes) * 11 * bit_cycles * 20 + 20000;

  logic          clk;
  logic          rstn;
  logic          rxd;
  logic          txd;
  logic          core_end;
  logic          data_ready_io;
  io_pkg::word_t data_from_memory_io;
  logic          wr_en_instr;
  io_pkg::addr_t addr_in_instr;
  io_pkg::word_t data_in_instr;
  io_pkg::addr_t addr_io;
  logic          memread_io;
  logic          core_start;
  logic          byte_valid;
  io_pkg::byte_t byte_data;
  logic          byte_stop;

  io_pkg::word_t rng_state;
  io_pkg::word_t prog [prog_words];
  int            rx_count;
  int            wr_count;
  int            read_count;
  int            mem_delay;
  logic          wr_prev;
  logic          start_prev;
  logic          mem_prev;
  logic          end_sent;

  io_top #(.clk_per_half_bit(half_bit), .img_side(img_side)) dut_i (
    .clk                 (clk),
    .rstn                (rstn),
    .rxd                 (rxd),
    .txd                 (txd),
    .core_end            (core_end),
    .data_ready_io       (data_ready_io),
    .data_from_memory_io (data_from_memory_io),
    .wr_en_instr         (wr_en_instr),
    .addr_in_instr       (addr_in_instr),
    .data_in_instr       (data_in_instr),
    .addr_io             (addr_io),
    .memread_io          (memread_io),
    .core_start          (core_start)
  );

  uart_host #(.clk_per_half_bit(half_bit)) host_i (
    .clk        (clk),
    .txd        (txd),
    .rxd        (rxd),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_stop  (byte_stop)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic io_pkg::word_t xorshift(input io_pkg::word_t x);
    io_pkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // value of image word w with a few corner cases forced in
  function automatic io_pkg::byte_t mem_value(input int w);
    io_pkg::word_t h;
    case (w)
      0:       h = 32'd0;
      5:       h = 32'd9;
      10:      h = 32'd10;
      20:      h = 32'd99;
      33:      h = 32'd100;
      47:      h = 32'd255;
      default: h = xorshift(`IO_OUT_BASE + w);
    endcase
    return h[7:0];
  endfunction

  function automatic string header_text();
    return $sformatf("P3\n%0d %0d\n255\n", img_side, img_side);
  endfunction

  function automatic int total_bytes();
    string hdr;
    hdr = header_text();
    return 1 + hdr.len() + 4 * n_words;
  endfunction

  // byte n of the whole txd stream
  function automatic io_pkg::byte_t ref_byte(input int n);
    string         hdr;
    int            k;
    int            v;
    io_pkg::byte_t b;
    hdr = header_text();
    if (n == 0) begin
      b = 8'h99;
    end else if (n <= hdr.len()) begin
      b = hdr[n-1];
    end else begin
      k = n - 1 - hdr.len();
      v = mem_value(k / 4);
      case (k % 4)
        0:       b = 48 + v / 100;
        1:       b = 48 + (v / 10) % 10;
        2:       b = 48 + v % 10;
        default: b = ((k / 4) % 3 == 2) ? 8'h0a : 8'h20; // newline ends a pixel
      endcase
    end
    return b;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    abort_run($sformatf("watchdog expired after %0d ns, the DUT stopped responding",
                        watchdog_ns));
  end

  always @(negedge clk) begin : compare_bytes
    io_pkg::byte_t exp;
    if (byte_valid) begin
      assert (byte_stop)
        else abort_run($sformatf("stop bit of txd byte %0d was not 1", rx_count));
      assert (rx_count < total_bytes())
        else abort_run("more bytes came out on txd than expected");
      exp = ref_byte(rx_count);
      assert (byte_data == exp)
        else abort_run($sformatf("mismatch at %0t ns: txd byte %0d got 8'h%02h expected 8'h%02h",
                                 $time, rx_count, byte_data, exp));
      rx_count++;
    end
  end

  always @(negedge clk) begin
    if (rstn) begin
      if (core_start && !start_prev) begin
        assert (wr_count == prog_words && wr_prev)
          else abort_run("core_start rose before the last instruction write");
      end
      assert (core_start || !start_prev) else abort_run("core_start fell before reset");
      assert (!(wr_en_instr && wr_prev))
        else abort_run("wr_en_instr stayed high for more than one cycle");
      assert (!(memread_io && mem_prev))
        else abort_run("memread_io stayed high for more than one cycle");
      if (wr_en_instr) begin
        assert (!core_start) else abort_run("instruction write while core_start is high");
        assert (wr_count < prog_words) else abort_run("more write strobes than program words");
        assert (addr_in_instr == 4 * wr_count)
          else abort_run($sformatf("mismatch at %0t ns: addr_in_instr got %0d expected %0d",
                                   $time, addr_in_instr, 4 * wr_count));
        assert (data_in_instr == prog[wr_count])
          else abort_run($sformatf(
                 "mismatch at %0t ns: data_in_instr got 32'h%08h expected 32'h%08h",
                 $time, data_in_instr, prog[wr_count]));
        wr_count++;
      end
      wr_prev    = wr_en_instr;
      start_prev = core_start;
      mem_prev   = memread_io;
    end
  end

  // memory model answers each read after 1 to 3 cycles
  always @(negedge clk) begin
    if (rstn && memread_io) begin
      assert (end_sent) else abort_run("memread_io pulsed before core_end");
      assert (read_count < n_words) else abort_run("more memory reads than image words");
      assert (addr_io == 4 * (`IO_OUT_BASE + read_count))
        else abort_run($sformatf("mismatch at %0t ns: addr_io got %0d expected %0d",
                                 $time, addr_io, 4 * (`IO_OUT_BASE + read_count)));
      rng_state = xorshift(rng_state);
      mem_delay = 1 + rng_state % 3;
      repeat (mem_delay) @(posedge clk);
      #2;
      data_ready_io       = 1'b1;
      data_from_memory_io = {24'h0, mem_value(read_count)};
      read_count++;
      @(posedge clk);
      #2;
      data_ready_io = 1'b0;
    end
  end

  initial begin : main
    io_pkg::word_t word;
    logic          got_start;
    rstn                = 1'b0;
    core_end            = 1'b0;
    data_ready_io       = 1'b0;
    data_from_memory_io = '0;
    rng_state           = 32'h7830;
    rx_count            = 0;
    wr_count            = 0;
    read_count          = 0;
    wr_prev             = 1'b0;
    start_prev          = 1'b0;
    mem_prev            = 1'b0;
    end_sent            = 1'b0;
    got_start           = 1'b0;
    for (int i = 0; i < prog_words; i++) begin
      rng_state = xorshift(rng_state);
      prog[i]   = rng_state;
    end

    repeat (5) @(posedge clk);
    #2;
    rstn = 1'b1;
    @(negedge clk);
    assert (!wr_en_instr && !memread_io && !core_start)
      else abort_run("an output was active right after reset");
    repeat (2) begin
      if (txd === 1'b0) got_start = 1'b1;
      @(negedge clk);
    end
    if (txd === 1'b0) got_start = 1'b1;
    assert (got_start) else abort_run("boot byte did not start within 2 cycles of reset");

    wait (rx_count == 1); // boot byte seen
    word = 4 * prog_words;
    for (int b = 0; b < 4; b++) host_i.send_byte(word[8*b +: 8], 1'b1);
    for (int w = 0; w < prog_words; w++) begin
      word = prog[w];
      for (int b = 0; b < 4; b++) begin
        if (w == 5 && b == 2) host_i.send_byte(~word[8*b +: 8], 1'b0); // framing error
        host_i.send_byte(word[8*b +: 8], 1'b1);
      end
    end

    wait (core_start === 1'b1);
    assert (wr_count == prog_words) else abort_run("core_start high with words missing");
    repeat (10) @(posedge clk);
    #2;
    core_end = 1'b1;
    end_sent = 1'b1;
    @(posedge clk);
    #2;
    core_end = 1'b0;

    wait (rx_count == total_bytes());
    repeat (4 * 11 * bit_cycles) @(posedge clk); // room for stray bytes
    assert (read_count == n_words)
      else abort_run($sformatf("%0d memory reads seen, %0d expected", read_count, n_words));
    assert (wr_count == prog_words && core_start)
      else abort_run("write count or core_start wrong at the end of the run");
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/uart_host.sv
`timescale 1ns/1ns
`default_nettype none

module uart_host #(
  parameter int clk_per_half_bit = 4
) (
  input  wire           clk,
  input  wire           txd,
  output logic          rxd,
  output logic          byte_valid,
  output io_pkg::byte_t byte_data,
  output logic          byte_stop
);

  localparam int bit_cycles = 2 * clk_per_half_bit;

  io_pkg::byte_t shreg;
  logic          stop_seen;

  // one bit on rxd, changed just after the rising edge
  task automatic drive_bit(input logic value);
    @(posedge clk);
    #2;
    rxd = value;
    repeat (bit_cycles - 1) @(posedge clk);
  endtask

  task automatic send_byte(input io_pkg::byte_t value, input logic stop_bit);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(value[i]); // lsb first
    end
    drive_bit(stop_bit);
    drive_bit(1'b1); // idle bit so a bad frame ends cleanly
  endtask

  initial begin : collect
    rxd        = 1'b1;
    byte_valid = 1'b0;
    byte_data  = '0;
    byte_stop  = 1'b1;
    forever begin
      @(negedge txd);
      repeat (clk_per_half_bit) @(negedge clk); // near middle of start bit
      for (int i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(negedge clk);
        shreg[i] = txd;
      end
      repeat (bit_cycles) @(negedge clk);
      stop_seen = txd;
      @(posedge clk);
      #2;
      byte_data  = shreg;
      byte_stop  = stop_seen;
      byte_valid = 1'b1;
      @(posedge clk);
      #2;
      byte_valid = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/boot_loader.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_defines.svh"

module boot_loader (
  input  wire                clk,
  input  wire                rstn,
  input  wire                rx_valid,
  input  wire io_pkg::byte_t rx_data,
  input  wire                tx_ack,
  output logic               tx_req,
  output io_pkg::byte_t      tx_data,
  output logic               wr_en_instr,
  output io_pkg::addr_t      addr_in_instr,
  output io_pkg::word_t      data_in_instr,
  output logic               core_start
);

  io_pkg::loader_state_t state;
  io_pkg::word_t shreg;
  io_pkg::word_t asm_next;
  io_pkg::word_t word_cnt;
  io_pkg::word_t word_idx;
  logic [1:0]    byte_idx;

  assign asm_next      = {rx_data, shreg[31:8]}; // little endian
  assign tx_req        = (state == io_pkg::L_BOOT);
  assign tx_data       = `IO_BOOT_BYTE;
  assign wr_en_instr   = (state == io_pkg::L_WRITE);
  assign addr_in_instr = {word_idx[29:0], 2'b00};
  assign data_in_instr = shreg;

  always_ff @(posedge clk) begin
    if (rx_valid && (state == io_pkg::L_LEN || state == io_pkg::L_WORD)) begin
      shreg <= asm_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= io_pkg::L_BOOT;
      byte_idx   <= '0;
      word_cnt   <= '0;
      word_idx   <= '0;
      core_start <= 1'b0;
    end else begin
      case (state)
        io_pkg::L_BOOT: begin
          if (tx_ack) state <= io_pkg::L_LEN;
        end
        io_pkg::L_LEN: begin
          if (rx_valid) begin
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == 2'd3) begin
              word_cnt <= {2'b00, asm_next[31:2]}; // bytes / 4
              if (asm_next[31:2] == '0) begin
                core_start <= 1'b1; // empty program
                state      <= io_pkg::L_RUN;
              end else begin
                state <= io_pkg::L_WORD;
              end
            end
          end
        end
        io_pkg::L_WORD: begin
          if (rx_valid) begin
            byte_idx <= byte_idx + 1'b1;
            if (byte_idx == 2'd3) state <= io_pkg::L_WRITE;
          end
        end
        io_pkg::L_WRITE: begin
          word_idx <= word_idx + 32'd1;
          if (word_idx + 32'd1 == word_cnt) begin
            core_start <= 1'b1;
            state      <= io_pkg::L_RUN;
          end else begin
            state <= io_pkg::L_WORD;
          end
        end
        default: ; // core runs, loader is done
      endcase
    end
  end

  a_no_late_write: assert property (@(posedge clk) disable iff (!rstn)
    core_start |=> core_start && !wr_en_instr);

endmodule

`default_nettype wire

// File: hdl/dec_digits.sv
`timescale 1ns/1ns
`default_nettype none

module dec_digits (
  input  wire                clk,
  input  wire                rstn,
  input  wire                conv_valid,
  input  wire io_pkg::byte_t conv_value,
  output logic               digits_valid,
  output io_pkg::digit_t     hundreds,
  output io_pkg::digit_t     tens,
  output io_pkg::digit_t     ones
);

  logic           valid_s1;
  io_pkg::digit_t hund_s1;
  io_pkg::byte_t  rem_s1;
  io_pkg::digit_t tens_c;
  io_pkg::byte_t  ones_c;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_s1     <= 1'b0;
      digits_valid <= 1'b0;
    end else begin
      valid_s1     <= conv_valid;
      digits_valid <= valid_s1;
    end
  end

  // stage one, hundreds
  always_ff @(posedge clk) begin
    if (conv_value >= 8'd200) begin
      hund_s1 <= 4'd2;
      rem_s1  <= conv_value - 8'd200;
    end else if (conv_value >= 8'd100) begin
      hund_s1 <= 4'd1;
      rem_s1  <= conv_value - 8'd100;
    end else begin
      hund_s1 <= 4'd0;
      rem_s1  <= conv_value;
    end
  end

  // remainder is below 100 here
  always_comb begin
    tens_c = '0;
    for (int i = 1; i < 10; i++) begin
      if (rem_s1 >= 8'(10 * i)) tens_c = 4'(i);
    end
    ones_c = rem_s1 - 8'd10 * {4'd0, tens_c};
  end

  always_ff @(posedge clk) begin
    hundreds <= hund_s1;
    tens     <= tens_c;
    ones     <= ones_c[3:0];
  end

endmodule

`default_nettype wire

// File: hdl/image_dumper.sv
`timescale 1ns/1ns
`default_nettype none
`include "io_defines.svh"

module image_dumper #(
  parameter int img_side = 128
) (
  input  wire                clk,
  input  wire                rstn,
  input  wire                core_end,
  input  wire                tx_ack,
  output logic               tx_req,
  output io_pkg::byte_t      tx_data,
  output logic               memread_io,
  output io_pkg::addr_t      addr_io,
  input  wire                data_ready_io,
  input  wire io_pkg::word_t data_from_memory_io
);

  localparam io_pkg::word_t n_words = 3 * img_side * img_side;
  // steps 0..8 are the header, then read and separator per word
  localparam logic [3:0] step_read = 4'd9;
  localparam logic [3:0] step_sep  = 4'd10;

  io_pkg::dumper_state_t state;
  logic [3:0]     step;
  logic [1:0]     comp;
  logic [1:0]     dig_idx;
  logic           strip;
  logic           skip;
  logic           is_num;
  io_pkg::word_t  word_idx;
  io_pkg::word_t  word_addr;
  io_pkg::byte_t  lit;
  io_pkg::byte_t  conv_value;
  logic           conv_valid;
  logic           digits_valid;
  io_pkg::digit_t hundreds;
  io_pkg::digit_t tens;
  io_pkg::digit_t ones;
  io_pkg::digit_t dig [3];

  dec_digits conv_i (
    .clk          (clk),
    .rstn         (rstn),
    .conv_valid   (conv_valid),
    .conv_value   (conv_value),
    .digits_valid (digits_valid),
    .hundreds     (hundreds),
    .tens         (tens),
    .ones         (ones)
  );

  assign word_addr = `IO_OUT_BASE + word_idx;
  assign addr_io   = {word_addr[29:0], 2'b00};
  assign is_num    = (step == 4'd3) || (step == 4'd5) || (step == 4'd7) || (step == step_read);

  always_comb begin
    case (step)
      4'd0:     lit = `IO_ASCII_P;
      4'd1:     lit = `IO_ASCII_ZERO + 8'd3;
      4'd4:     lit = `IO_ASCII_SPACE;
      step_sep: lit = (comp == 2'd2) ? `IO_ASCII_NL : `IO_ASCII_SPACE;
      default:  lit = `IO_ASCII_NL; // end of header lines
    endcase
  end

  // header numbers lose their leading zeros, the ones digit always goes out
  always_comb begin
    case (dig_idx)
      2'd0:    skip = strip && (dig[0] == 4'd0);
      2'd1:    skip = strip && (dig[0] == 4'd0) && (dig[1] == 4'd0);
      default: skip = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= io_pkg::D_IDLE;
      step       <= '0;
      comp       <= '0;
      dig_idx    <= '0;
      strip      <= 1'b0;
      word_idx   <= '0;
      tx_req     <= 1'b0;
      memread_io <= 1'b0;
      conv_valid <= 1'b0;
    end else begin
      memread_io <= 1'b0;
      conv_valid <= 1'b0;
      case (state)
        io_pkg::D_IDLE: begin
          if (core_end) state <= io_pkg::D_STEP;
        end
        io_pkg::D_STEP: begin
          if (step == step_read) begin
            memread_io <= 1'b1;
            strip      <= 1'b0;
            state      <= io_pkg::D_WAIT;
          end else if (is_num) begin
            conv_value <= (step == 4'd7) ? `IO_MAX_COLOR : io_pkg::byte_t'(img_side);
            conv_valid <= 1'b1;
            strip      <= 1'b1;
            state      <= io_pkg::D_CONV;
          end else begin
            tx_data <= lit;
            tx_req  <= 1'b1;
            state   <= io_pkg::D_SEND;
          end
        end
        io_pkg::D_WAIT: begin
          if (data_ready_io) begin
            conv_value <= data_from_memory_io[7:0];
            conv_valid <= 1'b1;
            word_idx   <= word_idx + 32'd1;
            state      <= io_pkg::D_CONV;
          end
        end
        io_pkg::D_CONV: begin
          if (digits_valid) begin
            dig[0]  <= hundreds;
            dig[1]  <= tens;
            dig[2]  <= ones;
            dig_idx <= '0;
            state   <= io_pkg::D_DIGIT;
          end
        end
        io_pkg::D_DIGIT: begin
          if (skip) begin
            dig_idx <= dig_idx + 1'b1;
          end else begin
            tx_data <= `IO_ASCII_ZERO + {4'd0, dig[dig_idx]};
            tx_req  <= 1'b1;
            state   <= io_pkg::D_SEND;
          end
        end
        io_pkg::D_SEND: begin
          if (tx_ack) begin
            tx_req <= 1'b0;
            state  <= io_pkg::D_ACK;
          end
        end
        io_pkg::D_ACK: begin
          if (!tx_ack) begin
            if (is_num && dig_idx != 2'd2) begin
              dig_idx <= dig_idx + 1'b1;
              state   <= io_pkg::D_DIGIT;
            end else if (step == step_sep) begin
              comp <= (comp == 2'd2) ? 2'd0 : comp + 1'b1;
              if (word_idx == n_words) begin
                state <= io_pkg::D_DONE;
              end else begin
                step  <= step_read;
                state <= io_pkg::D_STEP;
              end
            end else begin
              step  <= step + 1'b1;
              state <= io_pkg::D_STEP;
            end
          end
        end
        default: ; // image sent
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/io_pkg.sv
`default_nettype none

package io_pkg;

  typedef logic [7:0]  byte_t;   // uart byte or ascii char
  typedef logic [31:0] word_t;   // memory word, program length
  typedef logic [31:0] addr_t;   // byte address
  typedef logic [3:0]  digit_t;  // one decimal digit

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_t;

  typedef enum logic [2:0] {
    L_BOOT,   // boot byte on the wire
    L_LEN,
    L_WORD,
    L_WRITE,
    L_RUN
  } loader_state_t;

  typedef enum logic [2:0] {
    D_IDLE,
    D_STEP,   // pick next char or number
    D_WAIT,
    D_CONV,
    D_DIGIT,
    D_SEND,
    D_ACK,
    D_DONE
  } dumper_state_t;

endpackage

`default_nettype wire

// File: hdl/io_top.sv
`timescale 1ns/1ns
`default_nettype none

module io_top #(
  parameter int clk_per_half_bit = 100,
  parameter int img_side         = 128
) (
  input  wire                clk,
  input  wire                rstn,
  input  wire                rxd,
  output logic               txd,
  input  wire                core_end,
  input  wire                data_ready_io,
  input  wire io_pkg::word_t data_from_memory_io,
  output logic               wr_en_instr,
  output io_pkg::addr_t      addr_in_instr,
  output io_pkg::word_t      data_in_instr,
  output io_pkg::addr_t      addr_io,
  output logic               memread_io,
  output logic               core_start
);

  io_pkg::byte_t rx_data;
  logic          rx_valid;
  logic          ld_req;
  io_pkg::byte_t ld_data;
  logic          dp_req;
  io_pkg::byte_t dp_data;
  logic          tx_req;
  io_pkg::byte_t tx_data;
  logic          tx_ack;

  // loader owns the line until the core starts
  assign tx_req  = ld_req | dp_req;
  assign tx_data = core_start ? dp_data : ld_data;

  uart_rx #(.clk_per_half_bit(clk_per_half_bit)) rx_i (
    .clk      (clk),
    .rstn     (rstn),
    .rxd      (rxd),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  uart_tx #(.clk_per_half_bit(clk_per_half_bit)) tx_i (
    .clk     (clk),
    .rstn    (rstn),
    .tx_req  (tx_req),
    .tx_data (tx_data),
    .tx_ack  (tx_ack),
    .txd     (txd)
  );

  boot_loader loader_i (
    .clk           (clk),
    .rstn          (rstn),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .tx_ack        (tx_ack),
    .tx_req        (ld_req),
    .tx_data       (ld_data),
    .wr_en_instr   (wr_en_instr),
    .addr_in_instr (addr_in_instr),
    .data_in_instr (data_in_instr),
    .core_start    (core_start)
  );

  image_dumper #(.img_side(img_side)) dumper_i (
    .clk                 (clk),
    .rstn                (rstn),
    .core_end            (core_end),
    .tx_ack              (tx_ack),
    .tx_req              (dp_req),
    .tx_data             (dp_data),
    .memread_io          (memread_io),
    .addr_io             (addr_io),
    .data_ready_io       (data_ready_io),
    .data_from_memory_io (data_from_memory_io)
  );

  a_one_requester: assert property (@(posedge clk) disable iff (!rstn)
    !(ld_req && dp_req) && (!dp_req || core_start));

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int clk_per_half_bit = 100
) (
  input  wire           clk,
  input  wire           rstn,
  input  wire           rxd,
  output io_pkg::byte_t rx_data,
  output logic          rx_valid
);

  localparam int bit_cycles = 2 * clk_per_half_bit;
  localparam int cnt_w = $clog2(bit_cycles + 1);

  io_pkg::uart_state_t state;
  logic [2:0]       rx_sync;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  io_pkg::byte_t    shreg;
  logic             rx_bit;
  logic             rx_fall;

  assign rx_bit  = rx_sync[1];
  assign rx_fall = rx_sync[2] & ~rx_sync[1]; // only an edge starts a frame
  assign rx_data = shreg;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= io_pkg::UART_IDLE;
      rx_sync  <= 3'b111;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[1:0], rxd};
      rx_valid <= 1'b0;
      case (state)
        io_pkg::UART_IDLE: begin
          cnt <= '0;
          if (rx_fall) state <= io_pkg::UART_START;
        end
        io_pkg::UART_START: begin
          if (cnt == cnt_w'(clk_per_half_bit - 1)) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_bit ? io_pkg::UART_IDLE : io_pkg::UART_DATA; // glitch check
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        io_pkg::UART_DATA: begin
          if (cnt == cnt_w'(bit_cycles - 1)) begin
            cnt     <= '0;
            shreg   <= {rx_bit, shreg[7:1]}; // lsb first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= io_pkg::UART_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == cnt_w'(bit_cycles - 1)) begin
            rx_valid <= rx_bit; // bad stop bit drops the byte
            state    <= io_pkg::UART_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  a_rx_pulse: assert property (@(posedge clk) disable iff (!rstn) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
  parameter int clk_per_half_bit = 100
) (
  input  wire                clk,
  input  wire                rstn,
  input  wire                tx_req,
  input  wire io_pkg::byte_t tx_data,
  output logic               tx_ack,
  output logic               txd
);

  localparam int bit_cycles = 2 * clk_per_half_bit;
  localparam int cnt_w = $clog2(bit_cycles + 1);

  io_pkg::uart_state_t state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  io_pkg::byte_t    shreg;
  logic             bit_end;

  assign bit_end = (cnt == cnt_w'(bit_cycles - 1));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= io_pkg::UART_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_ack  <= 1'b0;
      txd     <= 1'b1;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        io_pkg::UART_IDLE: begin
          cnt <= '0;
          if (tx_ack && !tx_req) tx_ack <= 1'b0; // closes the handshake
          if (tx_req && !tx_ack) begin
            shreg <= tx_data;
            txd   <= 1'b0;
            state <= io_pkg::UART_START;
          end
        end
        io_pkg::UART_START: begin
          if (bit_end) begin
            txd     <= shreg[0];
            shreg   <= shreg >> 1;
            bit_idx <= '0;
            state   <= io_pkg::UART_DATA;
          end
        end
        io_pkg::UART_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;
              state <= io_pkg::UART_STOP;
            end else begin
              txd   <= shreg[0];
              shreg <= shreg >> 1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            tx_ack <= 1'b1; // stop bit done
            state  <= io_pkg::UART_IDLE;
          end
        end
      endcase
    end
  end

  a_data_stable: assert property (@(posedge clk) disable iff (!rstn)
    tx_req && !tx_ack |=> !tx_req || $stable(tx_data));

endmodule

`default_nettype wire

// File: include/io_defines.svh
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// sent once after reset, host answers with the program
`define IO_BOOT_BYTE   8'h99

// image region in data memory, word address
`define IO_OUT_BASE    32'd16384

`define IO_MAX_COLOR   8'd255

// ascii
`define IO_ASCII_ZERO  8'h30
`define IO_ASCII_SPACE 8'h20
`define IO_ASCII_NL    8'h0a
`define IO_ASCII_P     8'h50

`endif

// File: sources.f
+incdir+include
hdl/io_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/boot_loader.sv
hdl/dec_digits.sv
hdl/image_dumper.sv
hdl/io_top.sv
dv/uart_host.sv
dv/io_tb.sv
